/* design/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    localparam int CSR_NUM_W  = 14;
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;
    localparam int HWI_N      = 8;

    localparam logic [ESUBCODE_W-1:0] ADEM_SUB = 9'd1;  // data-side address error
    localparam logic [8:0] CRMD_RESET = 9'h008;         // only da set
    localparam int LIE_TIMER_BIT = 11;
    localparam int TICLR_CLR_BIT = 0;

    typedef enum logic [2:0] {
        CSR_NOP   = 3'd0,
        CSR_RD    = 3'd1,
        CSR_WR    = 3'd2,
        CSR_XCHG  = 3'd3,
        CSR_ERTN  = 3'd4,
        CSR_ENTRY = 3'd5     // exception or interrupt entry
    } csr_op_e;

    typedef enum logic [ECODE_W-1:0] {
        ECODE_INT = 6'h00,
        ECODE_ADE = 6'h08,
        ECODE_ALE = 6'h09,
        ECODE_SYS = 6'h0b,
        ECODE_BRK = 6'h0c,
        ECODE_INE = 6'h0d
    } ecode_e;

    typedef enum logic [CSR_NUM_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_BADV   = 14'h007,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_addr_e;

    typedef struct packed {
        logic                  valid;
        csr_op_e               op;
        logic [CSR_NUM_W-1:0]  num;
        logic [31:0]           wdata;
        logic [31:0]           wmask;
        logic [31:0]           pc;
        logic                  excp;
        ecode_e                ecode;
        logic [ESUBCODE_W-1:0] esubcode;
        logic [31:0]           badv;
    } csr_req_t;

    typedef struct packed {
        logic                  run;
        csr_op_e               op;
        logic [CSR_NUM_W-1:0]  num;
        logic [31:0]           wval;     // already merged with old value
        logic [31:0]           pc;
        ecode_e                ecode;
        logic [ESUBCODE_W-1:0] esubcode;
        logic [31:0]           badv;
    } csr_stage_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } csr_redirect_t;

    typedef struct packed {
        logic [1:0] datm;
        logic [1:0] datf;
        logic       pg;
        logic       da;
        logic       ie;
        logic [1:0] plv;
    } csr_crmd_t;

endpackage

`default_nettype wire

/* design/csr_timer.sv */
`default_nettype none

module csr_timer
    import csr_pkg::*;
#(
    parameter int TIMER_N = 32
)
(
    input  wire                clk,
    input  wire                rstn,
    input  wire [TIMER_N-1:0]  tcfg,
    input  wire                tcfg_wr,
    input  wire                ti_clr,
    output logic [TIMER_N-1:0] tval,
    output logic               ti
);

    logic               en;
    logic               periodic;
    logic [TIMER_N-1:0] init;

    assign en       = tcfg[0];
    assign periodic = tcfg[1];
    assign init     = {tcfg[TIMER_N-1:2], 2'b00};

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tval <= '0;
            ti   <= 1'b0;
        end
        else
        begin
            if (ti_clr)
                ti <= 1'b0;
            else if (tval == '0 && en && !tcfg_wr)
                ti <= 1'b1;

            if (en && (tcfg_wr || (periodic && tval == '0)))
                tval <= init;
            else if (en && tval != '1)
                tval <= tval - 1'b1;  // one-shot parks at all ones
        end
    end

endmodule

`default_nettype wire

/* design/csr_issue.sv */
`default_nettype none

module csr_issue
    import csr_pkg::*;
(
    input  wire                  clk,
    input  wire                  rstn,
    input  wire csr_req_t        req,
    input  wire                  stall,
    input  wire                  flush,
    input  wire                  int_pending,
    input  wire [31:0]           rd_data,
    input  wire [31:0]           era,
    input  wire [31:0]           eentry,
    output logic [CSR_NUM_W-1:0] rd_num,
    output csr_stage_t           stage,
    output logic [31:0]          rdata,
    output csr_redirect_t        redirect
);

    logic                  take_int;
    logic                  accept;
    logic                  go;
    logic                  entry_inflight;
    logic                  use_badv;
    csr_op_e               op;
    ecode_e                ecode;
    logic [ESUBCODE_W-1:0] esubcode;
    logic [31:0]           badv;
    logic [31:0]           mask;
    logic [31:0]           wval;
    csr_redirect_t         redir;

    // interrupt is held off until the ie clear of the last entry lands
    assign take_int = int_pending && !entry_inflight;
    assign accept   = req.valid && !stall && !flush;
    assign go       = take_int || accept;

    assign rd_num = req.num;

    // priority: interrupt, exception, request
    always_comb
    begin
        op       = req.op;
        ecode    = req.ecode;
        esubcode = req.esubcode;
        if (take_int)
        begin
            op       = CSR_ENTRY;
            ecode    = ECODE_INT;
            esubcode = '0;
        end
        else if (req.excp)
        begin
            op = CSR_ENTRY;
        end
    end

    assign use_badv = (ecode == ECODE_ALE) ||
                      (ecode == ECODE_ADE && esubcode == ADEM_SUB);
    assign badv = use_badv ? req.badv : req.pc;  // fetch side faults report pc

    assign mask = (op == CSR_WR) ? '1 : req.wmask;
    assign wval = (rd_data & ~mask) | (req.wdata & mask);

    always_comb
    begin
        redir.valid = 1'b0;
        redir.pc    = req.pc + 32'd4;
        case (op)
            CSR_WR, CSR_XCHG:
                redir.valid = 1'b1;  // refetch after csr side effects
            CSR_ERTN:
            begin
                redir.valid = 1'b1;
                redir.pc    = era;
            end
            CSR_ENTRY:
            begin
                redir.valid = 1'b1;
                redir.pc    = eentry;
            end
            default:
                redir.valid = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            stage.run      <= 1'b0;
            redirect.valid <= 1'b0;
            entry_inflight <= 1'b0;
        end
        else
        begin
            stage.run      <= go;
            redirect.valid <= go && redir.valid;
            entry_inflight <= go && (op == CSR_ENTRY);
            if (go)
            begin
                stage.op       <= op;
                stage.num      <= req.num;
                stage.wval     <= wval;
                stage.pc       <= req.pc;
                stage.ecode    <= ecode;
                stage.esubcode <= esubcode;
                stage.badv     <= badv;
                rdata          <= rd_data;
                redirect.pc    <= redir.pc;
            end
        end
    end

endmodule

`default_nettype wire

/* design/csr_regfile.sv */
`default_nettype none

module csr_regfile
    import csr_pkg::*;
#(
    parameter int TIMER_N = 32
)
(
    input  wire                  clk,
    input  wire                  rstn,
    input  wire csr_stage_t      stage,
    input  wire [CSR_NUM_W-1:0]  rd_num,
    input  wire [HWI_N-1:0]      hw_int,
    input  wire [TIMER_N-1:0]    tval,
    input  wire                  ti,
    output logic [31:0]          rd_data,
    output logic [31:0]          era,
    output logic [31:0]          eentry,
    output logic                 int_pending,
    output logic [TIMER_N-1:0]   tcfg,
    output logic                 tcfg_wr,
    output logic                 ti_clr,
    output logic                 excp_flush,
    output logic                 ertn_flush,
    output csr_crmd_t            crmd
);

    csr_crmd_t             crmd_n;
    logic [2:0]            prmd, prmd_n;        // {pie, pplv}
    logic [11:0]           lie, lie_n;
    logic [1:0]            estat_is, is_n;
    logic [ECODE_W-1:0]    estat_ecode, ecode_n;
    logic [ESUBCODE_W-1:0] estat_esub, esub_n;
    logic [31:0]           era_q, era_n;
    logic [31:0]           badv, badv_n;
    logic [31:6]           eentry_q, eentry_n;
    logic [31:0]           save [4];
    logic [31:0]           save_n [4];
    logic [31:0]           tid, tid_n;
    logic [TIMER_N-1:0]    tcfg_n;
    logic                  tcfg_wr_n;
    logic                  excp_n;
    logic                  ertn_n;
    logic [11:0]           irq_now;
    logic [11:0]           irq_rd;

    // commit of the issue stage, computed ahead so reads see it
    always_comb
    begin
        crmd_n    = crmd;
        prmd_n    = prmd;
        lie_n     = lie;
        is_n      = estat_is;
        ecode_n   = estat_ecode;
        esub_n    = estat_esub;
        era_n     = era_q;
        badv_n    = badv;
        eentry_n  = eentry_q;
        save_n    = save;
        tid_n     = tid;
        tcfg_n    = tcfg;
        tcfg_wr_n = 1'b0;
        ti_clr    = 1'b0;
        excp_n    = 1'b0;
        ertn_n    = 1'b0;
        if (stage.run)
        begin
            case (stage.op)
                CSR_ENTRY:
                begin
                    prmd_n     = {crmd.ie, crmd.plv};
                    crmd_n.plv = 2'b00;
                    crmd_n.ie  = 1'b0;
                    era_n      = stage.pc;
                    ecode_n    = stage.ecode;
                    esub_n     = stage.esubcode;
                    if (stage.ecode == ECODE_ADE || stage.ecode == ECODE_ALE)
                        badv_n = stage.badv;
                    excp_n     = 1'b1;
                end
                CSR_ERTN:
                begin
                    crmd_n.plv = prmd[1:0];
                    crmd_n.ie  = prmd[2];
                    ertn_n     = 1'b1;
                end
                CSR_WR, CSR_XCHG:
                begin
                    case (stage.num)
                        CSR_CRMD:   crmd_n = stage.wval[8:0];
                        CSR_PRMD:   prmd_n = stage.wval[2:0];
                        CSR_ECFG:
                        begin
                            lie_n     = stage.wval[11:0];
                            lie_n[10] = 1'b0;  // reserved
                        end
                        CSR_ESTAT:  is_n     = stage.wval[1:0];  // only sw bits
                        CSR_ERA:    era_n    = stage.wval;
                        CSR_BADV:   badv_n   = stage.wval;
                        CSR_EENTRY: eentry_n = stage.wval[31:6];
                        CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                            save_n[stage.num[1:0]] = stage.wval;
                        CSR_TID:    tid_n    = stage.wval;
                        CSR_TCFG:
                        begin
                            tcfg_n    = stage.wval[TIMER_N-1:0];
                            tcfg_wr_n = 1'b1;
                        end
                        CSR_TICLR:  ti_clr   = stage.wval[TICLR_CLR_BIT];
                        default:    ti_clr   = 1'b0;  // unknown numbers ignored
                    endcase
                end
                default:
                    ti_clr = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd        <= CRMD_RESET;
            prmd        <= '0;
            lie         <= '0;
            estat_is    <= '0;
            estat_ecode <= '0;
            estat_esub  <= '0;
            era_q       <= '0;
            badv        <= '0;
            eentry_q    <= '0;
            for (int i = 0; i < 4; i++)
                save[i] <= '0;
            tid         <= '0;
            tcfg        <= '0;
            tcfg_wr     <= 1'b0;
            excp_flush  <= 1'b0;
            ertn_flush  <= 1'b0;
        end
        else
        begin
            crmd        <= crmd_n;
            prmd        <= prmd_n;
            lie         <= lie_n;
            estat_is    <= is_n;
            estat_ecode <= ecode_n;
            estat_esub  <= esub_n;
            era_q       <= era_n;
            badv        <= badv_n;
            eentry_q    <= eentry_n;
            save        <= save_n;
            tid         <= tid_n;
            tcfg        <= tcfg_n;
            tcfg_wr     <= tcfg_wr_n;  // lines up with the new tcfg
            excp_flush  <= excp_n;
            ertn_flush  <= ertn_n;
        end
    end

    // estat.is layout: sw 1:0, hw 9:2, timer 11
    always_comb
    begin
        irq_now                = {2'b00, hw_int, estat_is};
        irq_now[LIE_TIMER_BIT] = ti;
        irq_rd                 = {2'b00, hw_int, is_n};
        irq_rd[LIE_TIMER_BIT]  = ti && !ti_clr;
    end

    assign int_pending = crmd.ie && |(irq_now & lie);

    assign era    = era_n;
    assign eentry = {eentry_n, 6'b0};

    always_comb
    begin
        rd_data = '0;
        case (rd_num)
            CSR_CRMD:   rd_data = {23'b0, crmd_n};
            CSR_PRMD:   rd_data = {29'b0, prmd_n};
            CSR_ECFG:   rd_data = {20'b0, lie_n};
            CSR_ESTAT:  rd_data = {1'b0, esub_n, ecode_n, 4'b0, irq_rd};
            CSR_ERA:    rd_data = era_n;
            CSR_BADV:   rd_data = badv_n;
            CSR_EENTRY: rd_data = {eentry_n, 6'b0};
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                rd_data = save_n[rd_num[1:0]];
            CSR_TID:    rd_data = tid_n;
            CSR_TCFG:   rd_data = 32'(tcfg_n);
            CSR_TVAL:   rd_data = 32'(tval);
            default:    rd_data = '0;  // ticlr and unknown read zero
        endcase
    end

endmodule

`default_nettype wire

/* design/csr_unit.sv */
`default_nettype none

module csr_unit
    import csr_pkg::*;
#(
    parameter int TIMER_N = 32
)
(
    input  wire               clk,
    input  wire               rstn,
    input  wire csr_req_t     req,
    input  wire               stall,
    input  wire               flush,
    input  wire [HWI_N-1:0]   hw_int,
    output logic [31:0]       rdata,
    output csr_redirect_t     redirect,
    output logic              excp_flush,
    output logic              ertn_flush,
    output csr_crmd_t         crmd
);

    csr_stage_t           stage;
    logic [CSR_NUM_W-1:0] rd_num;
    logic [31:0]          rd_data;
    logic [31:0]          era;
    logic [31:0]          eentry;
    logic                 int_pending;
    logic [TIMER_N-1:0]   tcfg;
    logic [TIMER_N-1:0]   tval;
    logic                 tcfg_wr;
    logic                 ti_clr;
    logic                 ti;

    csr_issue u_issue (
        .clk         (clk),
        .rstn        (rstn),
        .req         (req),
        .stall       (stall),
        .flush       (flush),
        .int_pending (int_pending),
        .rd_data     (rd_data),
        .era         (era),
        .eentry      (eentry),
        .rd_num      (rd_num),
        .stage       (stage),
        .rdata       (rdata),
        .redirect    (redirect)
    );

    csr_regfile #(.TIMER_N(TIMER_N)) u_regfile (
        .clk         (clk),
        .rstn        (rstn),
        .stage       (stage),
        .rd_num      (rd_num),
        .hw_int      (hw_int),
        .tval        (tval),
        .ti          (ti),
        .rd_data     (rd_data),
        .era         (era),
        .eentry      (eentry),
        .int_pending (int_pending),
        .tcfg        (tcfg),
        .tcfg_wr     (tcfg_wr),
        .ti_clr      (ti_clr),
        .excp_flush  (excp_flush),
        .ertn_flush  (ertn_flush),
        .crmd        (crmd)
    );

    csr_timer #(.TIMER_N(TIMER_N)) u_timer (
        .clk     (clk),
        .rstn    (rstn),
        .tcfg    (tcfg),
        .tcfg_wr (tcfg_wr),
        .ti_clr  (ti_clr),
        .tval    (tval),
        .ti      (ti)
    );

endmodule

`default_nettype wire

/* test/csr_unit_chk.sv */
`default_nettype none

module csr_unit_chk
    import csr_pkg::*;
(
    input wire                clk,
    input wire                rstn,
    input wire csr_redirect_t redirect,
    input wire                excp_flush,
    input wire                ertn_flush
);

    timeunit 1ns;
    timeprecision 100ps;

    int   fail_cnt = 0;
    logic was_in_reset = 1'b0;  // rstn low at the previous edge

    always_ff @(posedge clk)
        was_in_reset <= !rstn;

    // every flush pulse sits one cycle behind its redirect
    flush_after_redirect: assert property (@(posedge clk) disable iff (!rstn)
        (excp_flush || ertn_flush) |-> $past(redirect.valid))
    else
    begin
        $error("flush pulse without a redirect in the cycle before");
        fail_cnt++;
    end

    flush_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(excp_flush && ertn_flush))
    else
    begin
        $error("excp_flush and ertn_flush high in the same cycle");
        fail_cnt++;
    end

    quiet_in_reset: assert property (@(posedge clk)
        was_in_reset |-> !(redirect.valid || excp_flush || ertn_flush))
    else
    begin
        $error("output pulse while in reset");
        fail_cnt++;
    end

endmodule

bind csr_unit csr_unit_chk u_chk (
    .clk        (clk),
    .rstn       (rstn),
    .redirect   (redirect),
    .excp_flush (excp_flush),
    .ertn_flush (ertn_flush)
);

`default_nettype wire

/* test/tb_csr_unit.sv */
`default_nettype none

module tb_csr_unit
    import csr_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMER_INIT  = 40;  // low two bits zero
    localparam int RESET_CYC   = 8;
    // rough cycle budget of each test: reset, rw, entry, ertn, stall, timer
    localparam int TEST_CYC    = 20 + 600 + 300 + 200 + 300 + 500;
    localparam int TIMEOUT_CYC = 2 * TEST_CYC;

    logic          clk = 1'b0;
    logic          rstn;
    csr_req_t      req;
    logic          stall;
    logic          flush;
    logic [7:0]    hw_int;
    logic [31:0]   rdata;
    csr_redirect_t redirect;
    logic          excp_flush;
    logic          ertn_flush;
    csr_crmd_t     crmd;

    int            cycle = 0;
    int            err_cnt = 0;
    logic [31:0]   lfsr = 32'd83703;
    logic [31:0]   pc = 32'h1c00_0000;
    logic [13:0]   rw_list [6] = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID, CSR_ERA};

    // reference model of the kept csrs
    logic [8:0]    m_crmd = 9'h008;
    logic [2:0]    m_prmd = '0;  // {pie, pplv}
    logic [11:0]   m_lie = '0;
    logic [1:0]    m_is = '0;
    logic [5:0]    m_ecode = '0;
    logic [8:0]    m_esub = '0;
    logic          m_ti = 1'b0;
    logic [31:0]   m_era = '0;
    logic [31:0]   m_badv = '0;
    logic [31:0]   m_eentry = '0;
    logic [31:0]   m_save [4] = '{default: '0};
    logic [31:0]   m_tid = '0;
    logic [31:0]   m_tcfg = '0;

    always #10 clk = ~clk;

    csr_unit #(.TIMER_N(32)) i_csr_unit (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .stall      (stall),
        .flush      (flush),
        .hw_int     (hw_int),
        .rdata      (rdata),
        .redirect   (redirect),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush),
        .crmd       (crmd)
    );

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYC)
        begin
            $display("run stopped at cycle %0d, the tests did not finish in time", cycle);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_word(input int nbits);
        logic [31:0] val;
        logic        fb;
        int          i;
        val = '0;
        for (i = 0; i < nbits; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic [31:0] model_read(input logic [13:0] num);
        logic [31:0] v;
        v = '0;
        case (num)
            CSR_CRMD:   v = {23'b0, m_crmd};
            CSR_PRMD:   v = {29'b0, m_prmd};
            CSR_ECFG:   v = {20'b0, m_lie};
            CSR_ESTAT:  v = {1'b0, m_esub, m_ecode, 4'b0, m_ti, 1'b0, 8'b0, m_is};  // hw_int idle
            CSR_ERA:    v = m_era;
            CSR_BADV:   v = m_badv;
            CSR_EENTRY: v = m_eentry;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                v = m_save[num[1:0]];
            CSR_TID:    v = m_tid;
            CSR_TCFG:   v = m_tcfg;
            default:    v = '0;
        endcase
        return v;
    endfunction

    function automatic void model_write(input logic [13:0] num, input logic [31:0] v);
        case (num)
            CSR_CRMD:   m_crmd = v[8:0];
            CSR_PRMD:   m_prmd = v[2:0];
            CSR_ECFG:   m_lie = v[11:0] & 12'hbff;  // bit 10 reserved
            CSR_ESTAT:  m_is = v[1:0];
            CSR_ERA:    m_era = v;
            CSR_BADV:   m_badv = v;
            CSR_EENTRY: m_eentry = {v[31:6], 6'b0};
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                m_save[num[1:0]] = v;
            CSR_TID:    m_tid = v;
            CSR_TCFG:   m_tcfg = v;
            CSR_TICLR:  m_ti = m_ti && !v[0];
            default:    m_tid = m_tid;
        endcase
    endfunction

    function automatic void model_entry(input ecode_e ec, input logic [8:0] sub,
                                        input logic [31:0] addr);
        m_prmd      = m_crmd[2:0];
        m_crmd[2:0] = 3'b000;
        m_era       = pc;
        m_ecode     = ec;
        m_esub      = sub;
        if (ec == ECODE_ALE || (ec == ECODE_ADE && sub == ADEM_SUB))
            m_badv = addr;
        else if (ec == ECODE_ADE)
            m_badv = pc;  // fetch side
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            err_cnt++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic set_req(input csr_op_e op, input logic [13:0] num,
                           input logic [31:0] wdata, input logic [31:0] wmask);
        pc        = pc + 32'd4;
        req       = '0;
        req.valid = 1'b1;
        req.op    = op;
        req.num   = num;
        req.wdata = wdata;
        req.wmask = wmask;
        req.pc    = pc;
    endtask

    // one request, result checked in the cycle after acceptance
    task automatic access(input csr_op_e op, input logic [13:0] num,
                          input logic [31:0] wdata, input logic [31:0] wmask);
        logic [31:0] old;
        logic [31:0] m;
        logic        wr;
        old = model_read(num);
        m   = (op == CSR_WR) ? '1 : wmask;
        wr  = (op == CSR_WR || op == CSR_XCHG);
        set_req(op, num, wdata, wmask);
        tick();
        req.valid = 1'b0;
        check_val("rdata", rdata, old);
        check_val("redirect.valid", 32'(redirect.valid), 32'(wr));
        if (wr)
        begin
            check_val("redirect.pc", redirect.pc, pc + 32'd4);
            model_write(num, (old & ~m) | (wdata & m));
        end
    endtask

    task automatic enter_exception(input ecode_e ec, input logic [8:0] sub,
                                   input logic [31:0] addr);
        set_req(CSR_RD, CSR_SAVE0, '0, '0);
        req.excp     = 1'b1;
        req.ecode    = ec;
        req.esubcode = sub;
        req.badv     = addr;
        tick();
        req.valid = 1'b0;
        req.excp  = 1'b0;
        check_val("redirect.valid", 32'(redirect.valid), 32'd1);
        check_val("redirect.pc", redirect.pc, m_eentry);
        tick();
        model_entry(ec, sub, addr);
        check_val("excp_flush", 32'(excp_flush), 32'd1);
        check_val("crmd", 32'(crmd), 32'(m_crmd));
    endtask

    task automatic return_from_exception();
        set_req(CSR_ERTN, '0, '0, '0);
        tick();
        req.valid = 1'b0;
        check_val("redirect.valid", 32'(redirect.valid), 32'd1);
        check_val("redirect.pc", redirect.pc, m_era);
        tick();
        m_crmd[2:0] = m_prmd;
        check_val("ertn_flush", 32'(ertn_flush), 32'd1);
        check_val("excp_flush", 32'(excp_flush), 32'd0);
        check_val("crmd", 32'(crmd), 32'(m_crmd));
    endtask

    initial
    begin
        int n;
        int chk_errs;
        rstn   = 1'b0;
        req    = '0;
        stall  = 1'b0;
        flush  = 1'b0;
        hw_int = '0;
        repeat (RESET_CYC) @(posedge clk);
        #2;
        rstn = 1'b1;
        tick();

        access(CSR_RD, CSR_CRMD, '0, '0);
        access(CSR_RD, CSR_SAVE0, '0, '0);

        foreach (rw_list[i])
        begin
            access(CSR_WR, rw_list[i], rand_word(32), '0);
            access(CSR_RD, rw_list[i], '0, '0);
        end
        access(CSR_XCHG, CSR_SAVE1, rand_word(32), rand_word(32));
        access(CSR_RD, CSR_SAVE1, '0, '0);
        access(CSR_WR, CSR_CRMD, rand_word(32), '0);
        access(CSR_RD, CSR_CRMD, '0, '0);
        access(CSR_WR, CSR_ECFG, 32'hffff_ffff, '0);
        access(CSR_RD, CSR_ECFG, '0, '0);
        access(CSR_WR, CSR_ECFG, 32'h0, '0);
        access(CSR_WR, 14'h100, rand_word(32), '0);  // unknown number
        access(CSR_RD, 14'h100, '0, '0);

        access(CSR_WR, CSR_EENTRY, 32'h1c00_8abc, '0);
        access(CSR_WR, CSR_CRMD, 32'h0000_000f, '0);  // plv 3, ie
        enter_exception(ECODE_ALE, 9'd0, rand_word(32));
        access(CSR_RD, CSR_ERA, '0, '0);
        access(CSR_RD, CSR_BADV, '0, '0);
        access(CSR_RD, CSR_ESTAT, '0, '0);
        access(CSR_RD, CSR_PRMD, '0, '0);
        access(CSR_RD, CSR_CRMD, '0, '0);

        return_from_exception();
        access(CSR_RD, CSR_CRMD, '0, '0);
        enter_exception(ECODE_ADE, 9'd0, rand_word(32));  // badv takes the pc
        access(CSR_RD, CSR_BADV, '0, '0);
        return_from_exception();

        stall = 1'b1;
        set_req(CSR_WR, CSR_SAVE2, rand_word(32), '0);
        repeat (3)
        begin
            tick();
            check_val("redirect.valid", 32'(redirect.valid), 32'd0);
        end
        stall = 1'b0;
        tick();
        req.valid = 1'b0;
        check_val("rdata", rdata, m_save[2]);
        check_val("redirect.valid", 32'(redirect.valid), 32'd1);
        m_save[2] = req.wdata;
        tick();
        check_val("redirect.valid", 32'(redirect.valid), 32'd0);  // only one result
        access(CSR_RD, CSR_SAVE2, '0, '0);

        flush = 1'b1;
        set_req(CSR_WR, CSR_SAVE3, rand_word(32), '0);
        tick();
        req.valid = 1'b0;
        flush     = 1'b0;
        check_val("redirect.valid", 32'(redirect.valid), 32'd0);
        tick();
        check_val("redirect.valid", 32'(redirect.valid), 32'd0);
        access(CSR_RD, CSR_SAVE3, '0, '0);

        access(CSR_WR, CSR_CRMD, 32'h0000_000c, '0);  // da, ie
        access(CSR_WR, CSR_ECFG, 32'h1 << LIE_TIMER_BIT, '0);
        access(CSR_WR, CSR_TCFG, TIMER_INIT | 32'h1, '0);  // one-shot
        tick();
        n = 1;
        while (!redirect.valid && n < TIMER_INIT + 4)
        begin
            tick();
            n++;
        end
        assert (redirect.valid)
        else
        begin
            err_cnt++;
            $display("no timer interrupt entry within %0d cycles", TIMER_INIT + 4);
        end
        check_val("redirect.pc", redirect.pc, m_eentry);
        tick();
        m_ti = 1'b1;
        model_entry(ECODE_INT, 9'd0, '0);
        check_val("excp_flush", 32'(excp_flush), 32'd1);
        access(CSR_RD, CSR_ESTAT, '0, '0);
        access(CSR_WR, CSR_TICLR, 32'h1 << TICLR_CLR_BIT, '0);
        access(CSR_RD, CSR_ESTAT, '0, '0);
        access(CSR_RD, CSR_CRMD, '0, '0);

        tick();
        chk_errs = i_csr_unit.u_chk.fail_cnt;
        $display("errors: %0d in data checks, %0d in timing checks", err_cnt, chk_errs);
        if (err_cnt == 0 && chk_errs == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
design/csr_pkg.sv
design/csr_timer.sv
design/csr_issue.sv
design/csr_regfile.sv
design/csr_unit.sv
test/csr_unit_chk.sv
test/tb_csr_unit.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_csr_unit
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

.PHONY: sim clean
